// File: rtl/ex_pkg.sv
// ex stage constants; alu and mem op codes must match the decoder, MEM_TIMEOUT must fit TIMER_WD
`default_nettype none

package ex_pkg;

  localparam int WORD_WD       = 64;
  localparam int PC_WD         = 64;
  localparam int GPR_ADDR_WD   = 5;
  localparam int CSR_ADDR_WD   = 12;
  localparam int SRAM_ADDR_WD  = 32;
  localparam int SRAM_WMASK_WD = 8;

  // alu ops
  localparam int ALU_OP_WD = 5;
  localparam logic [ALU_OP_WD-1:0] ALU_ADD   = 5'd0;
  localparam logic [ALU_OP_WD-1:0] ALU_SUB   = 5'd1;
  localparam logic [ALU_OP_WD-1:0] ALU_SLL   = 5'd2;
  localparam logic [ALU_OP_WD-1:0] ALU_SLT   = 5'd3;
  localparam logic [ALU_OP_WD-1:0] ALU_SLTU  = 5'd4;
  localparam logic [ALU_OP_WD-1:0] ALU_XOR   = 5'd5;
  localparam logic [ALU_OP_WD-1:0] ALU_SRL   = 5'd6;
  localparam logic [ALU_OP_WD-1:0] ALU_SRA   = 5'd7;
  localparam logic [ALU_OP_WD-1:0] ALU_OR    = 5'd8;
  localparam logic [ALU_OP_WD-1:0] ALU_AND   = 5'd9;
  localparam logic [ALU_OP_WD-1:0] ALU_PASS2 = 5'd10; // lui

  localparam int SRC2_SEL_WD = 2;
  localparam logic [SRC2_SEL_WD-1:0] SRC2_RS2  = 2'd0;
  localparam logic [SRC2_SEL_WD-1:0] SRC2_IMM  = 2'd1;
  localparam logic [SRC2_SEL_WD-1:0] SRC2_FOUR = 2'd2; // jal/jalr link

  // csr ops follow funct3[1:0]
  localparam int CSR_OP_WD = 3;
  localparam logic [CSR_OP_WD-1:0] CSR_RW = 3'd1;
  localparam logic [CSR_OP_WD-1:0] CSR_RS = 3'd2;
  localparam logic [CSR_OP_WD-1:0] CSR_RC = 3'd3;

  // load/store funct3
  localparam int MEM_OP_WD = 3;
  localparam logic [MEM_OP_WD-1:0] MEM_B  = 3'd0;
  localparam logic [MEM_OP_WD-1:0] MEM_H  = 3'd1;
  localparam logic [MEM_OP_WD-1:0] MEM_W  = 3'd2;
  localparam logic [MEM_OP_WD-1:0] MEM_D  = 3'd3;
  localparam logic [MEM_OP_WD-1:0] MEM_BU = 3'd4;
  localparam logic [MEM_OP_WD-1:0] MEM_HU = 3'd5;
  localparam logic [MEM_OP_WD-1:0] MEM_WU = 3'd6;

  localparam int TIMER_WD = 5;
  localparam logic [TIMER_WD-1:0] MEM_TIMEOUT = 5'd16; // cycles without response

  // sram access fsm
  localparam int ST_WD = 2;
  localparam logic [ST_WD-1:0] ST_IDLE = 2'd0;
  localparam logic [ST_WD-1:0] ST_REQ  = 2'd1;
  localparam logic [ST_WD-1:0] ST_WAIT = 2'd2;
  localparam logic [ST_WD-1:0] ST_DONE = 2'd3;

endpackage

`default_nettype wire

// File: rtl/ex_alu.sv
// combinational ALU and CSR rmw; word cut follows RV64 *W rules, unknown op codes give zero
`timescale 1ns/10ps
`default_nettype none

module ex_alu (
  input  wire  [ex_pkg::WORD_WD-1:0]     i_rs1data,
  input  wire  [ex_pkg::WORD_WD-1:0]     i_rs2data,
  input  wire  [ex_pkg::WORD_WD-1:0]     i_imm,
  input  wire  [ex_pkg::PC_WD-1:0]       i_pc,
  input  wire  [ex_pkg::WORD_WD-1:0]     i_csrrdata,
  input  wire                            i_src1_sel,
  input  wire  [ex_pkg::SRC2_SEL_WD-1:0] i_src2_sel,
  input  wire  [ex_pkg::ALU_OP_WD-1:0]   i_alu_op,
  input  wire                            i_word_cut,
  input  wire  [ex_pkg::CSR_OP_WD-1:0]   i_csr_op,
  output logic [ex_pkg::WORD_WD-1:0]     o_alu_result,
  output logic [ex_pkg::WORD_WD-1:0]     o_csr_result
);

  logic [ex_pkg::WORD_WD-1:0] src1;
  logic [ex_pkg::WORD_WD-1:0] src2;
  logic [5:0]                 shamt;
  logic [ex_pkg::WORD_WD-1:0] srl_in;
  logic [ex_pkg::WORD_WD-1:0] sra_in;
  logic [ex_pkg::WORD_WD-1:0] raw;

  assign src1 = i_src1_sel ? i_pc : i_rs1data; // pc for auipc and jal

  always_comb begin
    case (i_src2_sel)
      ex_pkg::SRC2_RS2:  src2 = i_rs2data;
      ex_pkg::SRC2_IMM:  src2 = i_imm;
      ex_pkg::SRC2_FOUR: src2 = 64'd4;
      default:           src2 = '0;
    endcase
  end

  // word shifts only see the low 32 bits of src1
  assign shamt  = i_word_cut ? {1'b0, src2[4:0]} : src2[5:0];
  assign srl_in = i_word_cut ? {32'b0, src1[31:0]} : src1;
  assign sra_in = i_word_cut ? {{32{src1[31]}}, src1[31:0]} : src1;

  always_comb begin
    case (i_alu_op)
      ex_pkg::ALU_ADD:   raw = src1 + src2;
      ex_pkg::ALU_SUB:   raw = src1 - src2;
      ex_pkg::ALU_SLL:   raw = src1 << shamt;
      ex_pkg::ALU_SLT:   raw = {63'b0, $signed(src1) < $signed(src2)};
      ex_pkg::ALU_SLTU:  raw = {63'b0, src1 < src2};
      ex_pkg::ALU_XOR:   raw = src1 ^ src2;
      ex_pkg::ALU_SRL:   raw = srl_in >> shamt;
      ex_pkg::ALU_SRA:   raw = $signed(sra_in) >>> shamt;
      ex_pkg::ALU_OR:    raw = src1 | src2;
      ex_pkg::ALU_AND:   raw = src1 & src2;
      ex_pkg::ALU_PASS2: raw = src2;
      default:           raw = '0;
    endcase
  end

  assign o_alu_result = i_word_cut ? {{32{raw[31]}}, raw[31:0]} : raw;

  always_comb begin
    case (i_csr_op)
      ex_pkg::CSR_RW: o_csr_result = i_rs1data;
      ex_pkg::CSR_RS: o_csr_result = i_csrrdata | i_rs1data;
      ex_pkg::CSR_RC: o_csr_result = i_csrrdata & ~i_rs1data;
      default:        o_csr_result = i_csrrdata; // csr left as it was
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/ex_store_align.sv
// store lane alignment; misaligned stores are not detected and their mask is simply truncated
`timescale 1ns/10ps
`default_nettype none

module ex_store_align (
  input  wire  [ex_pkg::MEM_OP_WD-1:0]     i_mem_op,
  input  wire  [2:0]                       i_addr_low,
  input  wire  [ex_pkg::WORD_WD-1:0]       i_wdata,
  output logic [ex_pkg::SRAM_WMASK_WD-1:0] o_wmask,
  output logic [ex_pkg::WORD_WD-1:0]       o_wdata
);

  logic [ex_pkg::SRAM_WMASK_WD-1:0] base_mask;

  // size from funct3, unsigned variants only matter for loads
  always_comb begin
    case (i_mem_op)
      ex_pkg::MEM_B,
      ex_pkg::MEM_BU: base_mask = 8'h01;
      ex_pkg::MEM_H,
      ex_pkg::MEM_HU: base_mask = 8'h03;
      ex_pkg::MEM_W,
      ex_pkg::MEM_WU: base_mask = 8'h0f;
      ex_pkg::MEM_D:  base_mask = 8'hff;
      default:        base_mask = '0;
    endcase
  end

  assign o_wmask = base_mask << i_addr_low;
  assign o_wdata = i_wdata << {i_addr_low, 3'b000}; // byte offset to bit offset

endmodule

`default_nettype wire

// File: rtl/ex_mem_fsm.sv
// one data SRAM access per instruction; a response arriving after a timeout is not filtered
`timescale 1ns/10ps
`default_nettype none

module ex_mem_fsm (
  input  wire  i_clk,
  input  wire  i_arst_n,
  input  wire  i_es_valid,
  input  wire  i_mem_ren,
  input  wire  i_mem_wen,
  input  wire  i_ms_allowin,
  input  wire  i_leave,
  input  wire  i_addr_ok,
  input  wire  i_data_ok,
  input  wire  i_expired,
  output logic o_req,
  output logic o_done,
  output logic o_fault,
  output logic o_timer_run
);

  logic [ex_pkg::ST_WD-1:0] state;
  logic [ex_pkg::ST_WD-1:0] state_nxt;
  logic                     fault_q;
  logic                     issue;

  // loads wait for ms_allowin, stores go at once
  assign issue = i_es_valid & (i_mem_wen | (i_mem_ren & i_ms_allowin));

  always_comb begin
    state_nxt = state;
    case (state)
      ex_pkg::ST_IDLE: begin
        if (issue) begin
          state_nxt = i_addr_ok ? ex_pkg::ST_WAIT : ex_pkg::ST_REQ;
        end
      end
      ex_pkg::ST_REQ: begin
        if (i_addr_ok) begin
          state_nxt = ex_pkg::ST_WAIT;
        end else if (i_expired) begin
          state_nxt = ex_pkg::ST_DONE; // never granted
        end
      end
      ex_pkg::ST_WAIT: begin
        if (i_data_ok || i_expired) begin
          state_nxt = ex_pkg::ST_DONE;
        end
      end
      default: begin
        if (i_leave) begin
          state_nxt = ex_pkg::ST_IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state   <= ex_pkg::ST_IDLE;
      fault_q <= 1'b0;
    end else begin
      state <= state_nxt;
      if (i_leave) begin
        fault_q <= 1'b0;
      end else if (state != ex_pkg::ST_DONE && state_nxt == ex_pkg::ST_DONE) begin
        fault_q <= ~i_data_ok; // ended by expiry
      end
    end
  end

  assign o_req       = (state == ex_pkg::ST_REQ) | ((state == ex_pkg::ST_IDLE) & issue);
  assign o_done      = (state == ex_pkg::ST_DONE);
  assign o_fault     = fault_q;
  assign o_timer_run = (state == ex_pkg::ST_REQ) | (state == ex_pkg::ST_WAIT);

endmodule

`default_nettype wire

// File: rtl/ex_resp_timer.sv
// response timer; saturates at MEM_TIMEOUT and clears in any cycle where run is low
`timescale 1ns/10ps
`default_nettype none

module ex_resp_timer (
  input  wire  i_clk,
  input  wire  i_arst_n,
  input  wire  i_run,
  output logic o_expired
);

  logic [ex_pkg::TIMER_WD-1:0] count;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      count <= '0;
    end else if (!i_run) begin
      count <= '0;
    end else if (count != ex_pkg::MEM_TIMEOUT) begin
      count <= count + 1'b1;
    end
  end

  assign o_expired = (count == ex_pkg::MEM_TIMEOUT);

endmodule

`default_nettype wire

// File: rtl/ex_stage.sv
// RV64 execute stage; decoder must keep mem_ren and mem_wen exclusive, only one SRAM access in flight
`timescale 1ns/10ps
`default_nettype none

module ex_stage (
  input  wire                              i_clk,
  input  wire                              i_arst_n,
  // from ds
  input  wire                              i_ds_to_es_valid,
  input  wire  [ex_pkg::WORD_WD-1:0]       i_ds_rs1data,
  input  wire  [ex_pkg::WORD_WD-1:0]       i_ds_rs2data,
  input  wire  [ex_pkg::WORD_WD-1:0]       i_ds_csrrdata,
  input  wire  [ex_pkg::WORD_WD-1:0]       i_ds_imm,
  input  wire  [ex_pkg::PC_WD-1:0]         i_ds_pc,
  input  wire                              i_ds_alu_src1_sel,
  input  wire  [ex_pkg::SRC2_SEL_WD-1:0]   i_ds_alu_src2_sel,
  input  wire                              i_ds_alu_word_cut,
  input  wire  [ex_pkg::ALU_OP_WD-1:0]     i_ds_alu_op,
  input  wire  [ex_pkg::GPR_ADDR_WD-1:0]   i_ds_rd,
  input  wire  [ex_pkg::CSR_ADDR_WD-1:0]   i_ds_csr,
  input  wire                              i_ds_gpr_wen,
  input  wire                              i_ds_csr_wen,
  input  wire                              i_ds_mem_ren,
  input  wire                              i_ds_mem_wen,
  input  wire  [ex_pkg::MEM_OP_WD-1:0]     i_ds_mem_op,
  input  wire  [ex_pkg::CSR_OP_WD-1:0]     i_ds_csr_op,
  input  wire                              i_ds_load,
  output logic                             o_es_allowin,
  // to ms
  input  wire                              i_ms_allowin,
  output logic                             o_es_to_ms_valid,
  output logic [ex_pkg::GPR_ADDR_WD-1:0]   o_es_rd,
  output logic                             o_es_gpr_wen,
  output logic [ex_pkg::CSR_ADDR_WD-1:0]   o_es_csr,
  output logic                             o_es_csr_wen,
  output logic                             o_es_mem_ren,
  output logic [ex_pkg::MEM_OP_WD-1:0]     o_es_mem_op,
  output logic [ex_pkg::WORD_WD-1:0]       o_es_alu_result,
  output logic [ex_pkg::WORD_WD-1:0]       o_es_csr_result,
  output logic                             o_es_fault,
  // data sram
  output logic                             o_data_sram_req,
  output logic                             o_data_sram_wr,
  output logic [ex_pkg::SRAM_ADDR_WD-1:0]  o_data_sram_addr,
  output logic [ex_pkg::SRAM_WMASK_WD-1:0] o_data_sram_wmask,
  output logic [ex_pkg::WORD_WD-1:0]       o_data_sram_wdata,
  input  wire                              i_data_sram_addr_ok,
  input  wire                              i_data_sram_data_ok,
  // forward and load stall to ds
  output logic                             o_es_fwd_valid,
  output logic [ex_pkg::GPR_ADDR_WD-1:0]   o_es_fwd_rd,
  output logic [ex_pkg::WORD_WD-1:0]       o_es_fwd_data,
  output logic                             o_es_load
);

  logic                            es_valid;
  logic                            es_ready_go;
  logic                            es_leave;
  logic                            mem_done;
  logic                            timer_run;
  logic                            timer_expired;
  // latched fields
  logic [ex_pkg::WORD_WD-1:0]      es_rs1data;
  logic [ex_pkg::WORD_WD-1:0]      es_rs2data;
  logic [ex_pkg::WORD_WD-1:0]      es_csrrdata;
  logic [ex_pkg::WORD_WD-1:0]      es_imm;
  logic [ex_pkg::PC_WD-1:0]        es_pc;
  logic                            es_alu_src1_sel;
  logic [ex_pkg::SRC2_SEL_WD-1:0]  es_alu_src2_sel;
  logic                            es_alu_word_cut;
  logic [ex_pkg::ALU_OP_WD-1:0]    es_alu_op;
  logic [ex_pkg::MEM_OP_WD-1:0]    es_mem_op;
  logic [ex_pkg::CSR_OP_WD-1:0]    es_csr_op;
  logic                            es_mem_wen;
  logic                            es_load;

  assign es_ready_go      = (o_es_mem_ren | es_mem_wen) ? mem_done : 1'b1;
  assign o_es_allowin     = !es_valid || (es_ready_go && i_ms_allowin);
  assign o_es_to_ms_valid = es_valid && es_ready_go;
  assign es_leave         = o_es_to_ms_valid && i_ms_allowin;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      es_valid     <= 1'b0;
      o_es_gpr_wen <= 1'b0;
      o_es_csr_wen <= 1'b0;
      o_es_mem_ren <= 1'b0;
      es_mem_wen   <= 1'b0;
      es_load      <= 1'b0;
    end else begin
      if (o_es_allowin) begin
        es_valid <= i_ds_to_es_valid;
      end
      if (i_ds_to_es_valid && o_es_allowin) begin // accept
        o_es_gpr_wen <= i_ds_gpr_wen;
        o_es_csr_wen <= i_ds_csr_wen;
        o_es_mem_ren <= i_ds_mem_ren;
        es_mem_wen   <= i_ds_mem_wen;
        es_load      <= i_ds_load;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_ds_to_es_valid && o_es_allowin) begin
      es_rs1data      <= i_ds_rs1data;
      es_rs2data      <= i_ds_rs2data;
      es_csrrdata     <= i_ds_csrrdata;
      es_imm          <= i_ds_imm;
      es_pc           <= i_ds_pc;
      es_alu_src1_sel <= i_ds_alu_src1_sel;
      es_alu_src2_sel <= i_ds_alu_src2_sel;
      es_alu_word_cut <= i_ds_alu_word_cut;
      es_alu_op       <= i_ds_alu_op;
      o_es_rd         <= i_ds_rd;
      o_es_csr        <= i_ds_csr;
      es_mem_op       <= i_ds_mem_op;
      es_csr_op       <= i_ds_csr_op;
    end
  end

  assign o_es_mem_op    = es_mem_op;
  assign o_es_load      = es_valid & es_load;
  assign o_es_fwd_valid = es_valid & o_es_gpr_wen;
  assign o_es_fwd_rd    = o_es_rd;
  assign o_es_fwd_data  = o_es_alu_result;

  ex_alu u_alu (
    .i_rs1data    (es_rs1data),
    .i_rs2data    (es_rs2data),
    .i_imm        (es_imm),
    .i_pc         (es_pc),
    .i_csrrdata   (es_csrrdata),
    .i_src1_sel   (es_alu_src1_sel),
    .i_src2_sel   (es_alu_src2_sel),
    .i_alu_op     (es_alu_op),
    .i_word_cut   (es_alu_word_cut),
    .i_csr_op     (es_csr_op),
    .o_alu_result (o_es_alu_result),
    .o_csr_result (o_es_csr_result)
  );

  ex_store_align u_store_align (
    .i_mem_op   (es_mem_op),
    .i_addr_low (o_es_alu_result[2:0]), // rs1 + imm
    .i_wdata    (es_rs2data),
    .o_wmask    (o_data_sram_wmask),
    .o_wdata    (o_data_sram_wdata)
  );

  assign o_data_sram_wr   = es_mem_wen;
  assign o_data_sram_addr = o_es_alu_result[ex_pkg::SRAM_ADDR_WD-1:0];

  ex_mem_fsm u_mem_fsm (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_es_valid   (es_valid),
    .i_mem_ren    (o_es_mem_ren),
    .i_mem_wen    (es_mem_wen),
    .i_ms_allowin (i_ms_allowin),
    .i_leave      (es_leave),
    .i_addr_ok    (i_data_sram_addr_ok),
    .i_data_ok    (i_data_sram_data_ok),
    .i_expired    (timer_expired),
    .o_req        (o_data_sram_req),
    .o_done       (mem_done),
    .o_fault      (o_es_fault),
    .o_timer_run  (timer_run)
  );

  ex_resp_timer u_resp_timer (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .i_run     (timer_run),
    .o_expired (timer_expired)
  );

endmodule

`default_nettype wire

// File: test/ex_stage_sva.sv
// handshake and SRAM request properties; bound into every ex_stage instance, needs concurrent assertion support
`timescale 1ns/10ps
`default_nettype none

module ex_stage_sva (
  input wire        i_clk,
  input wire        i_arst_n,
  input wire        i_req,
  input wire        i_addr_ok,
  input wire [31:0] i_addr,
  input wire        i_to_ms_valid,
  input wire        i_ms_allowin,
  input wire        i_es_valid,
  input wire        i_timer_expired
);

  // an expired grant wait drops req legally
  req_held: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_req && !i_addr_ok && !i_timer_expired |=> i_req && $stable(i_addr))
    else $error("sram req dropped or address changed before addr_ok");

  valid_held: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_to_ms_valid && !i_ms_allowin |=> i_to_ms_valid)
    else $error("es_to_ms_valid dropped without a transfer");

  no_req_idle: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    !i_es_valid |-> !i_req)
    else $error("sram req raised while stage is empty");

endmodule

bind ex_stage ex_stage_sva u_sva (
  .i_clk           (i_clk),
  .i_arst_n        (i_arst_n),
  .i_req           (o_data_sram_req),
  .i_addr_ok       (i_data_sram_addr_ok),
  .i_addr          (o_data_sram_addr),
  .i_to_ms_valid   (o_es_to_ms_valid),
  .i_ms_allowin    (i_ms_allowin),
  .i_es_valid      (es_valid),
  .i_timer_expired (timer_expired)
);

`default_nettype wire

// File: test/ex_stage_tb.sv
// ex_stage testbench; one instruction in flight, SRAM responder never returns load data
`timescale 1ns/10ps
`default_nettype none

module ex_stage_tb;

  localparam int N_INSTR = 100;
  localparam int T_CLK   = 40;

  typedef struct packed {
    logic [63:0] alu;
    logic [63:0] csr;
    logic [7:0]  wmask;
    logic [63:0] wdata;
    logic [4:0]  rd;
    logic        gpr_wen;
    logic [11:0] csr_idx;
    logic        csr_wen;
    logic [2:0]  mem_op;
    logic        ren;
    logic        wen;
    logic        load;
    logic        fault;
    logic        chk_lat;
    int          acc;
  } exp_t;

  logic        i_clk, i_arst_n;
  logic        i_ds_to_es_valid, i_ds_alu_src1_sel, i_ds_alu_word_cut;
  logic [63:0] i_ds_rs1data, i_ds_rs2data, i_ds_csrrdata, i_ds_imm, i_ds_pc;
  logic [1:0]  i_ds_alu_src2_sel;
  logic [4:0]  i_ds_alu_op, i_ds_rd;
  logic [11:0] i_ds_csr;
  logic        i_ds_gpr_wen, i_ds_csr_wen, i_ds_mem_ren, i_ds_mem_wen, i_ds_load;
  logic [2:0]  i_ds_mem_op, i_ds_csr_op;
  logic        i_ms_allowin, i_data_sram_addr_ok, i_data_sram_data_ok;
  wire         o_es_allowin, o_es_to_ms_valid, o_es_gpr_wen, o_es_csr_wen, o_es_mem_ren;
  wire  [4:0]  o_es_rd, o_es_fwd_rd;
  wire  [11:0] o_es_csr;
  wire  [2:0]  o_es_mem_op;
  wire  [63:0] o_es_alu_result, o_es_csr_result, o_data_sram_wdata, o_es_fwd_data;
  wire         o_es_fault, o_data_sram_req, o_data_sram_wr, o_es_fwd_valid, o_es_load;
  wire  [31:0] o_data_sram_addr;
  wire  [7:0]  o_data_sram_wmask;

  integer seed = 86453;
  int     errors = 0;
  int     cycle = 0;
  string  test_name = "reset";
  bit     resp_on = 1;
  bit     rand_allow = 0;
  bit     lat_chk = 0;
  exp_t   exp_q[$];

  ex_stage dut (.*);

  always #(T_CLK/2) i_clk = ~i_clk;
  always @(posedge i_clk) cycle <= cycle + 1;

  // expected results straight from the RV64 rules
  function automatic exp_t ref_exec(logic [63:0] rs1, rs2, imm, pc, csrr, logic s1,
                                    logic [1:0] s2, logic [4:0] op, logic wc,
                                    logic [2:0] cop, logic [2:0] mop);
    exp_t        e;
    logic [63:0] a, b, r;
    logic [31:0] r32;
    int          lo;
    e = '0;
    a = s1 ? pc : rs1;
    b = (s2 == 2'd0) ? rs2 : (s2 == 2'd1) ? imm : (s2 == 2'd2) ? 64'd4 : 64'd0;
    case (op)
      5'd0:    r = a + b;
      5'd1:    r = a - b;
      5'd2:    r = a << b[5:0];
      5'd3:    r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      5'd4:    r = (a < b) ? 64'd1 : 64'd0;
      5'd5:    r = a ^ b;
      5'd6:    r = a >> b[5:0];
      5'd7:    r = $signed(a) >>> b[5:0];
      5'd8:    r = a | b;
      5'd9:    r = a & b;
      5'd10:   r = b;
      default: r = 64'd0;
    endcase
    if (wc) begin // *W forms on the low word
      case (op)
        5'd0:    r32 = a[31:0] + b[31:0];
        5'd1:    r32 = a[31:0] - b[31:0];
        5'd2:    r32 = a[31:0] << b[4:0];
        5'd6:    r32 = a[31:0] >> b[4:0];
        5'd7:    r32 = $signed(a[31:0]) >>> b[4:0];
        default: r32 = r[31:0];
      endcase
      r = {{32{r32[31]}}, r32};
    end
    e.alu = r;
    case (cop)
      3'd1:    e.csr = rs1;
      3'd2:    e.csr = csrr | rs1;
      3'd3:    e.csr = csrr & ~rs1;
      default: e.csr = csrr;
    endcase
    lo = r[2:0];
    e.wmask = ((16'd1 << (1 << mop[1:0])) - 16'd1) << lo;
    e.wdata = rs2 << (8 * lo);
    return e;
  endfunction

  task automatic check_val(string what, logic [63:0] exp_v, logic [63:0] act_v);
    assert (exp_v === act_v) else begin
      errors++;
      $display("Fail %s %s: expected %h, actual %h", test_name, what, exp_v, act_v);
    end
  endtask

  // comparing process, all sampling at the falling edge
  always @(negedge i_clk) begin
    exp_t h, e;
    if (i_arst_n) begin
      if (exp_q.size() != 0) begin
        h = exp_q[0];
        check_val("fwd_valid", h.gpr_wen, o_es_fwd_valid);
        check_val("load", h.load, o_es_load);
        if (h.gpr_wen) begin
          check_val("fwd_rd", h.rd, o_es_fwd_rd);
          check_val("fwd_data", h.alu, o_es_fwd_data);
        end
        if (o_data_sram_req) begin
          check_val("sram_addr", h.alu[31:0], o_data_sram_addr);
          check_val("sram_wr", h.wen, o_data_sram_wr);
          if (h.wen) begin
            check_val("wmask", h.wmask, o_data_sram_wmask);
            check_val("wdata", h.wdata, o_data_sram_wdata);
          end
        end
      end else begin
        assert (!o_es_to_ms_valid && !o_data_sram_req && !o_es_fwd_valid && !o_es_load)
        else begin
          errors++;
          $display("%s: stage drives valid outputs while it holds nothing", test_name);
        end
      end
      if (o_es_to_ms_valid && i_ms_allowin && exp_q.size() != 0) begin
        h = exp_q.pop_front();
        if (h.chk_lat) begin
          check_val("latency", h.acc + 1, cycle);
        end
        check_val("alu_result", h.alu, o_es_alu_result);
        check_val("csr_result", h.csr, o_es_csr_result);
        check_val("rd", h.rd, o_es_rd);
        check_val("gpr_wen", h.gpr_wen, o_es_gpr_wen);
        check_val("csr", h.csr_idx, o_es_csr);
        check_val("csr_wen", h.csr_wen, o_es_csr_wen);
        check_val("mem_op", h.mem_op, o_es_mem_op);
        check_val("mem_ren", h.ren, o_es_mem_ren);
        check_val("fault", h.fault, o_es_fault);
      end
      if (i_ds_to_es_valid && o_es_allowin) begin // accepted at the next edge
        e = ref_exec(i_ds_rs1data, i_ds_rs2data, i_ds_imm, i_ds_pc, i_ds_csrrdata,
                     i_ds_alu_src1_sel, i_ds_alu_src2_sel, i_ds_alu_op, i_ds_alu_word_cut,
                     i_ds_csr_op, i_ds_mem_op);
        e.rd      = i_ds_rd;
        e.gpr_wen = i_ds_gpr_wen;
        e.csr_idx = i_ds_csr;
        e.csr_wen = i_ds_csr_wen;
        e.mem_op  = i_ds_mem_op;
        e.ren     = i_ds_mem_ren;
        e.wen     = i_ds_mem_wen;
        e.load    = i_ds_load;
        e.fault   = (i_ds_mem_ren | i_ds_mem_wen) & !resp_on;
        e.chk_lat = lat_chk;
        e.acc     = cycle;
        exp_q.push_back(e);
      end
    end
  end

  // SRAM responder, addr_ok works as a ready level
  initial begin
    bit grant, req_seen, busy;
    int gwait, gdelay, dleft;
    busy = 0;
    gwait = 0;
    gdelay = 0;
    dleft = 0;
    forever begin
      @(negedge i_clk);
      grant = o_data_sram_req && i_data_sram_addr_ok;
      req_seen = o_data_sram_req;
      @(posedge i_clk);
      #2;
      i_data_sram_data_ok = 0;
      if (grant) begin
        busy = 1;
        dleft = 1 + $unsigned($random(seed)) % 4;
        gwait = 0;
        gdelay = $unsigned($random(seed)) % 4;
      end
      if (busy) begin
        dleft--;
        if (dleft == 0) begin
          i_data_sram_data_ok = 1;
          busy = 0;
        end
      end
      if (!busy && resp_on) begin
        if (req_seen && !grant) gwait++;
        i_data_sram_addr_ok = (gwait >= gdelay);
      end else begin
        i_data_sram_addr_ok = 0;
      end
    end
  end

  always @(posedge i_clk) begin
    #2;
    i_ms_allowin = rand_allow ? $random(seed) & 1 : 1'b1;
  end

  // kind 0 alu, 1 csr, 2 store, 3 load
  task automatic send_instr(int kind);
    bit acc;
    i_ds_rs1data      = {$random(seed), $random(seed)};
    i_ds_rs2data      = {$random(seed), $random(seed)};
    i_ds_csrrdata     = {$random(seed), $random(seed)};
    i_ds_imm          = {{32{1'b0}}, $random(seed)};
    i_ds_pc           = {$random(seed), $random(seed)};
    i_ds_alu_src1_sel = $random(seed);
    i_ds_alu_src2_sel = $unsigned($random(seed)) % 3;
    i_ds_alu_word_cut = $random(seed);
    i_ds_alu_op       = $unsigned($random(seed)) % 11;
    i_ds_rd           = $random(seed);
    i_ds_csr          = $random(seed);
    i_ds_gpr_wen      = (kind != 2);
    i_ds_csr_wen      = (kind == 1);
    i_ds_csr_op       = (kind == 1) ? 3'd1 + $unsigned($random(seed)) % 3 : 3'd0;
    i_ds_mem_ren      = (kind == 3);
    i_ds_mem_wen      = (kind == 2);
    i_ds_load         = (kind == 3);
    i_ds_mem_op       = $unsigned($random(seed)) % 4;
    if (kind >= 2) begin // address is rs1 + imm
      i_ds_alu_src1_sel = 0;
      i_ds_alu_src2_sel = 2'd1;
      i_ds_alu_word_cut = 0;
      i_ds_alu_op       = 5'd0;
    end
    i_ds_to_es_valid = 1;
    do begin
      @(negedge i_clk);
      acc = o_es_allowin;
      @(posedge i_clk);
      #2;
    end while (!acc);
    i_ds_to_es_valid = 0;
  endtask

  task automatic drain;
    do @(posedge i_clk); while (exp_q.size() != 0);
    #2;
  endtask

  initial begin
    #((N_INSTR * (ex_pkg::MEM_TIMEOUT + 8) + 10) * T_CLK);
    $display("watchdog expired, the stage hung with %0d instructions pending", exp_q.size());
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    {i_ds_to_es_valid, i_ds_alu_src1_sel, i_ds_alu_word_cut, i_ds_gpr_wen} = '0;
    {i_ds_csr_wen, i_ds_mem_ren, i_ds_mem_wen, i_ds_load} = '0;
    {i_ds_rs1data, i_ds_rs2data, i_ds_csrrdata, i_ds_imm, i_ds_pc} = '0;
    {i_ds_alu_src2_sel, i_ds_alu_op, i_ds_rd, i_ds_csr, i_ds_mem_op, i_ds_csr_op} = '0;
    i_ms_allowin = 1;
    i_data_sram_addr_ok = 0;
    i_data_sram_data_ok = 0;
    i_clk = 0;
    i_arst_n = 0;
    repeat (3) @(posedge i_clk);
    #2;
    i_arst_n = 1;
    check_val("allowin after reset", 1, o_es_allowin);
    test_name = "alu";
    lat_chk = 1;
    repeat (40) send_instr(0);
    drain();
    test_name = "csr";
    repeat (12) send_instr(1);
    drain();
    lat_chk = 0;
    test_name = "store";
    repeat (16) send_instr(2);
    drain();
    test_name = "mem_backpressure";
    rand_allow = 1;
    repeat (30) send_instr(($unsigned($random(seed)) % 2) ? 3 : 2);
    drain();
    rand_allow = 0;
    test_name = "timeout";
    resp_on = 0;
    send_instr(3);
    drain();
    resp_on = 1;
    send_instr(0);
    drain();
    $display("checks done, %0d errors", errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: ex_stage.f
rtl/ex_pkg.sv
rtl/ex_alu.sv
rtl/ex_store_align.sv
rtl/ex_mem_fsm.sv
rtl/ex_resp_timer.sv
rtl/ex_stage.sv
test/ex_stage_sva.sv
test/ex_stage_tb.sv
